/* riscPkg.sv */
package riscPkg;

    // --------------------------------------------------
    // widths
    localparam int dataWidth = 32;
    localparam int regAddrWidth = 5;
    localparam int aluOpWidth = 4;

    // --------------------------------------------------
    // opcodes that survive in this core
    localparam logic [6:0] opcodeReg = 7'b0110011;  // R-type alu
    localparam logic [6:0] opcodeImm = 7'b0010011;  // I-type alu
    localparam logic [6:0] opcodeLui = 7'b0110111;

    localparam logic [dataWidth-1:0] nopWord = 32'h0000_0013;  // addi x0,x0,0

    // --------------------------------------------------
    // alu operation codes
    localparam logic [aluOpWidth-1:0] aluAdd = 4'd0;
    localparam logic [aluOpWidth-1:0] aluSub = 4'd1;
    localparam logic [aluOpWidth-1:0] aluSll = 4'd2;
    localparam logic [aluOpWidth-1:0] aluSlt = 4'd3;
    localparam logic [aluOpWidth-1:0] aluSltu = 4'd4;
    localparam logic [aluOpWidth-1:0] aluXor = 4'd5;
    localparam logic [aluOpWidth-1:0] aluSrl = 4'd6;
    localparam logic [aluOpWidth-1:0] aluSra = 4'd7;
    localparam logic [aluOpWidth-1:0] aluOr = 4'd8;
    localparam logic [aluOpWidth-1:0] aluAnd = 4'd9;

    // --------------------------------------------------
    // instruction word, seen as R-type or I-type
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rTypeFields;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } iTypeFields;

    typedef union packed {
        rTypeFields r;
        iTypeFields i;
    } instrWord;

endpackage

/* issueIf.sv */
`timescale 1ns/1ps

interface issueIf;
    import riscPkg::*;

    logic writeEnable;
    logic [regAddrWidth-1:0] rd;
    logic [regAddrWidth-1:0] rs1;
    logic [regAddrWidth-1:0] rs2;
    logic [aluOpWidth-1:0] aluOp;
    logic useImm;                   // second operand from imm
    logic [dataWidth-1:0] imm;
    logic [dataWidth-1:0] readData1;
    logic [dataWidth-1:0] readData2;

    modport issuer (
        output writeEnable, rd, rs1, rs2, aluOp, useImm, imm, readData1, readData2
    );

    modport executor (
        input writeEnable, rd, rs1, rs2, aluOp, useImm, imm, readData1, readData2
    );

endinterface

/* regFile.sv */
`timescale 1ns/1ps

module regFile (
    input  logic clock,
    input  logic reset,
    input  logic [riscPkg::regAddrWidth-1:0] readAddrA1,
    input  logic [riscPkg::regAddrWidth-1:0] readAddrA2,
    input  logic [riscPkg::regAddrWidth-1:0] readAddrB1,
    input  logic [riscPkg::regAddrWidth-1:0] readAddrB2,
    output logic [riscPkg::dataWidth-1:0] readDataA1,
    output logic [riscPkg::dataWidth-1:0] readDataA2,
    output logic [riscPkg::dataWidth-1:0] readDataB1,
    output logic [riscPkg::dataWidth-1:0] readDataB2,
    input  logic writeA,
    input  logic [riscPkg::regAddrWidth-1:0] destA,
    input  logic [riscPkg::dataWidth-1:0] dataA,
    input  logic writeB,
    input  logic [riscPkg::regAddrWidth-1:0] destB,
    input  logic [riscPkg::dataWidth-1:0] dataB
);
    import riscPkg::*;

    localparam int regCount = 1 << regAddrWidth;

    logic [dataWidth-1:0] regs [1:regCount-1];  // x0 not stored
    logic [regAddrWidth-1:0] readAddr [4];
    logic [dataWidth-1:0] readData [4];

    assign readAddr = '{readAddrA1, readAddrA2, readAddrB1, readAddrB2};

    always_comb begin
        for (int p = 0; p < 4; p++) begin
            if (readAddr[p] == '0)
                readData[p] = '0;
            else if (writeB && destB == readAddr[p])
                readData[p] = dataB;          // write-through, B is younger
            else if (writeA && destA == readAddr[p])
                readData[p] = dataA;
            else
                readData[p] = regs[readAddr[p]];
        end
    end

    assign readDataA1 = readData[0];
    assign readDataA2 = readData[1];
    assign readDataB1 = readData[2];
    assign readDataB2 = readData[3];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int r = 1; r < regCount; r++)
                regs[r] <= '0;
        end else begin
            if (writeA && destA != '0)
                regs[destA] <= dataA;
            if (writeB && destB != '0)
                regs[destB] <= dataB;
        end
    end

    // the split in decode keeps the lanes from colliding
    assert property (@(posedge clock) disable iff (reset)
        !(writeA && writeB && destA == destB && destA != '0));

endmodule

/* decodeUnit.sv */
`timescale 1ns/1ps

module decodeUnit (
    input  logic clock,
    input  logic reset,
    input  logic packetValid,
    input  logic [riscPkg::dataWidth-1:0] instrA,
    input  logic [riscPkg::dataWidth-1:0] instrB,
    output logic stall,
    output logic [riscPkg::regAddrWidth-1:0] readAddrA1,
    output logic [riscPkg::regAddrWidth-1:0] readAddrA2,
    output logic [riscPkg::regAddrWidth-1:0] readAddrB1,
    output logic [riscPkg::regAddrWidth-1:0] readAddrB2,
    input  logic [riscPkg::dataWidth-1:0] readDataA1,
    input  logic [riscPkg::dataWidth-1:0] readDataA2,
    input  logic [riscPkg::dataWidth-1:0] readDataB1,
    input  logic [riscPkg::dataWidth-1:0] readDataB2,
    issueIf.issuer laneA,
    issueIf.issuer laneB
);
    import riscPkg::*;

    function automatic logic [aluOpWidth-1:0] aluFromFunct3(input logic [2:0] funct3,
                                                            input logic alt);
        case (funct3)
            3'b000: return alt ? aluSub : aluAdd;
            3'b001: return aluSll;
            3'b010: return aluSlt;
            3'b011: return aluSltu;
            3'b100: return aluXor;
            3'b101: return alt ? aluSra : aluSrl;
            3'b110: return aluOr;
            default: return aluAnd;
        endcase
    endfunction

    instrWord held [2];  // packet register, slot 0 is A
    logic [1:0] slotWrite;
    logic [1:0] slotUseImm;
    logic [regAddrWidth-1:0] slotRd [2];
    logic [regAddrWidth-1:0] slotRs1 [2];
    logic [regAddrWidth-1:0] slotRs2 [2];
    logic [aluOpWidth-1:0] slotOp [2];
    logic [dataWidth-1:0] slotImm [2];
    logic hazard;

    // --------------------------------------------------
    // packet register
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            held[0] <= '0;
            held[1] <= '0;
        end else if (hazard) begin
            held[0] <= nopWord;  // A already issued, B waits
        end else begin
            held[0] <= packetValid ? instrA : nopWord;
            held[1] <= packetValid ? instrB : nopWord;
        end
    end

    // --------------------------------------------------
    // per-slot decode
    always_comb begin
        logic legal;
        for (int s = 0; s < 2; s++) begin
            legal = 1'b0;
            slotOp[s] = aluAdd;
            slotUseImm[s] = 1'b0;
            slotImm[s] = '0;
            slotRd[s] = held[s].r.rd;
            slotRs1[s] = held[s].r.rs1;
            slotRs2[s] = '0;
            case (held[s].r.opcode)
                opcodeReg: begin
                    slotRs2[s] = held[s].r.rs2;
                    legal = (held[s].r.funct7 == 7'b0000000) ||
                            (held[s].r.funct7 == 7'b0100000 &&
                             (held[s].r.funct3 == 3'b000 || held[s].r.funct3 == 3'b101));
                    slotOp[s] = aluFromFunct3(held[s].r.funct3, held[s].r.funct7[5]);
                end
                opcodeImm: begin
                    slotUseImm[s] = 1'b1;
                    slotImm[s] = {{20{held[s].i.imm12[11]}}, held[s].i.imm12};
                    case (held[s].i.funct3)
                        3'b001: legal = held[s].i.imm12[11:5] == 7'b0000000;
                        3'b101: legal = held[s].i.imm12[11:5] == 7'b0000000 ||
                                        held[s].i.imm12[11:5] == 7'b0100000;
                        default: legal = 1'b1;
                    endcase
                    slotOp[s] = aluFromFunct3(held[s].i.funct3,
                        held[s].i.funct3 == 3'b101 && held[s].i.imm12[10]);
                end
                opcodeLui: begin
                    legal = 1'b1;
                    slotRs1[s] = '0;  // 0 + upper imm
                    slotUseImm[s] = 1'b1;
                    slotImm[s] = {held[s].i.imm12, held[s].i.rs1, held[s].i.funct3, 12'b0};
                end
                default: legal = 1'b0;
            endcase
            if (!legal) begin
                slotRd[s] = '0;
                slotRs1[s] = '0;
                slotRs2[s] = '0;
            end
            slotWrite[s] = legal && slotRd[s] != '0;
        end
    end

    // A writes something B needs or also writes
    assign hazard = slotWrite[0] && (slotRd[0] == slotRs1[1] || slotRd[0] == slotRs2[1] ||
                                     slotRd[0] == slotRd[1]);
    assign stall = hazard;

    assign readAddrA1 = slotRs1[0];
    assign readAddrA2 = slotRs2[0];
    assign readAddrB1 = slotRs1[1];
    assign readAddrB2 = slotRs2[1];

    // --------------------------------------------------
    // decode to execute registers
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            laneA.writeEnable <= 1'b0;
            laneA.rd <= '0;
            laneA.rs1 <= '0;
            laneA.rs2 <= '0;
            laneA.aluOp <= '0;
            laneA.useImm <= 1'b0;
            laneA.imm <= '0;
            laneA.readData1 <= '0;
            laneA.readData2 <= '0;
            laneB.writeEnable <= 1'b0;
            laneB.rd <= '0;
            laneB.rs1 <= '0;
            laneB.rs2 <= '0;
            laneB.aluOp <= '0;
            laneB.useImm <= 1'b0;
            laneB.imm <= '0;
            laneB.readData1 <= '0;
            laneB.readData2 <= '0;
        end else begin
            laneA.writeEnable <= slotWrite[0];
            laneA.rd <= slotRd[0];
            laneA.rs1 <= slotRs1[0];
            laneA.rs2 <= slotRs2[0];
            laneA.aluOp <= slotOp[0];
            laneA.useImm <= slotUseImm[0];
            laneA.imm <= slotImm[0];
            laneA.readData1 <= readDataA1;
            laneA.readData2 <= readDataA2;
            laneB.writeEnable <= slotWrite[1] && !hazard;  // bubble on split
            laneB.rd <= slotRd[1];
            laneB.rs1 <= slotRs1[1];
            laneB.rs2 <= slotRs2[1];
            laneB.aluOp <= slotOp[1];
            laneB.useImm <= slotUseImm[1];
            laneB.imm <= slotImm[1];
            laneB.readData1 <= readDataB1;
            laneB.readData2 <= readDataB2;
        end
    end

    // the leftover B after a split never splits again
    assert property (@(posedge clock) disable iff (reset)
        stall |=> !stall);

endmodule

/* executeUnit.sv */
`timescale 1ns/1ps

module executeUnit (
    input  logic clock,
    input  logic reset,
    issueIf.executor laneA,
    issueIf.executor laneB,
    output logic resWriteA,
    output logic [riscPkg::regAddrWidth-1:0] resDestA,
    output logic [riscPkg::dataWidth-1:0] resDataA,
    output logic resWriteB,
    output logic [riscPkg::regAddrWidth-1:0] resDestB,
    output logic [riscPkg::dataWidth-1:0] resDataB
);
    import riscPkg::*;

    function automatic logic [dataWidth-1:0] aluCompute(input logic [aluOpWidth-1:0] op,
                                                        input logic [dataWidth-1:0] a,
                                                        input logic [dataWidth-1:0] b);
        logic [dataWidth-1:0] result;
        result = '0;
        case (op)
            aluAdd: result = a + b;
            aluSub: result = a - b;
            aluSll: result = a << b[4:0];  // low five bits only
            aluSlt: result[0] = $signed(a) < $signed(b);
            aluSltu: result[0] = a < b;
            aluXor: result = a ^ b;
            aluSrl: result = a >> b[4:0];
            aluSra: result = $unsigned($signed(a) >>> b[4:0]);
            aluOr: result = a | b;
            aluAnd: result = a & b;
            default: result = '0;
        endcase
        return result;
    endfunction

    // --------------------------------------------------
    // forwarding, operands ordered A1 A2 B1 B2
    logic [regAddrWidth-1:0] src [4];
    logic [dataWidth-1:0] regValue [4];
    logic [dataWidth-1:0] fwdValue [4];
    logic [3:0] hitA;
    logic [3:0] hitB;
    logic [3:0] srcZero;
    logic [dataWidth-1:0] opA1;
    logic [dataWidth-1:0] opA2;
    logic [dataWidth-1:0] opB1;
    logic [dataWidth-1:0] opB2;

    assign src = '{laneA.rs1, laneA.rs2, laneB.rs1, laneB.rs2};
    assign regValue = '{laneA.readData1, laneA.readData2, laneB.readData1, laneB.readData2};

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            hitA[i] = resWriteA && resDestA == src[i];
            hitB[i] = resWriteB && resDestB == src[i];
            srcZero[i] = src[i] == '0;
            if (hitB[i])
                fwdValue[i] = resDataB;  // younger result wins
            else if (hitA[i])
                fwdValue[i] = resDataA;
            else
                fwdValue[i] = regValue[i];
        end
    end

    assign opA1 = fwdValue[0];
    assign opA2 = laneA.useImm ? laneA.imm : fwdValue[1];
    assign opB1 = fwdValue[2];
    assign opB2 = laneB.useImm ? laneB.imm : fwdValue[3];

    // --------------------------------------------------
    // result stage
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            resWriteA <= 1'b0;
            resDestA <= '0;
            resDataA <= '0;
            resWriteB <= 1'b0;
            resDestB <= '0;
            resDataB <= '0;
        end else begin
            resWriteA <= laneA.writeEnable;
            resDestA <= laneA.rd;
            resDataA <= aluCompute(laneA.aluOp, opA1, opA2);
            resWriteB <= laneB.writeEnable;
            resDestB <= laneB.rd;
            resDataB <= aluCompute(laneB.aluOp, opB1, opB2);
        end
    end

    // decode never enables a write to x0, so x0 is never forwarded
    assert property (@(posedge clock) disable iff (reset)
        ((hitA | hitB) & srcZero) == '0);

endmodule

/* dualIssueCore.sv */
`timescale 1ns/1ps

module dualIssueCore (
    input  logic clock,
    input  logic reset,
    input  logic packetValid,
    input  logic [riscPkg::dataWidth-1:0] instrA,
    input  logic [riscPkg::dataWidth-1:0] instrB,
    output logic stall,
    output logic wbWriteA,
    output logic [riscPkg::regAddrWidth-1:0] wbDestA,
    output logic [riscPkg::dataWidth-1:0] wbDataA,
    output logic wbWriteB,
    output logic [riscPkg::regAddrWidth-1:0] wbDestB,
    output logic [riscPkg::dataWidth-1:0] wbDataB
);
    import riscPkg::*;

    logic [regAddrWidth-1:0] readAddrA1;
    logic [regAddrWidth-1:0] readAddrA2;
    logic [regAddrWidth-1:0] readAddrB1;
    logic [regAddrWidth-1:0] readAddrB2;
    logic [dataWidth-1:0] readDataA1;
    logic [dataWidth-1:0] readDataA2;
    logic [dataWidth-1:0] readDataB1;
    logic [dataWidth-1:0] readDataB2;

    issueIf laneA ();
    issueIf laneB ();

    regFile regs (
        .clock(clock), .reset(reset),
        .readAddrA1(readAddrA1), .readAddrA2(readAddrA2),
        .readAddrB1(readAddrB1), .readAddrB2(readAddrB2),
        .readDataA1(readDataA1), .readDataA2(readDataA2),
        .readDataB1(readDataB1), .readDataB2(readDataB2),
        .writeA(wbWriteA), .destA(wbDestA), .dataA(wbDataA),  // result lanes write back
        .writeB(wbWriteB), .destB(wbDestB), .dataB(wbDataB)
    );

    decodeUnit decode (
        .clock(clock), .reset(reset),
        .packetValid(packetValid), .instrA(instrA), .instrB(instrB), .stall(stall),
        .readAddrA1(readAddrA1), .readAddrA2(readAddrA2),
        .readAddrB1(readAddrB1), .readAddrB2(readAddrB2),
        .readDataA1(readDataA1), .readDataA2(readDataA2),
        .readDataB1(readDataB1), .readDataB2(readDataB2),
        .laneA(laneA.issuer), .laneB(laneB.issuer)
    );

    executeUnit execute (
        .clock(clock), .reset(reset),
        .laneA(laneA.executor), .laneB(laneB.executor),
        .resWriteA(wbWriteA), .resDestA(wbDestA), .resDataA(wbDataA),
        .resWriteB(wbWriteB), .resDestB(wbDestB), .resDataB(wbDataB)
    );

endmodule

/* dualIssueTb.sv */
`timescale 1ns/1ps

module dualIssueTb;
    import riscPkg::*;

    localparam int packetCount = 400;
    localparam int cycleLimit = 4 * packetCount + 50;

    logic clock;
    logic reset;
    logic packetValid;
    logic [dataWidth-1:0] instrA;
    logic [dataWidth-1:0] instrB;
    logic stall;
    logic wbWriteA;
    logic [regAddrWidth-1:0] wbDestA;
    logic [dataWidth-1:0] wbDataA;
    logic wbWriteB;
    logic [regAddrWidth-1:0] wbDestB;
    logic [dataWidth-1:0] wbDataB;

    int seed = 32'h027c_ff67;
    int errorCount = 0;
    int checkedCount = 0;
    int acceptedCount = 0;
    int stallCycles = 0;
    int cycleCount = 0;
    logic holdPacket = 1'b0;
    logic splitNext = 1'b0;                  // stall due in the next cycle
    logic [regAddrWidth-1:0] packetDest;     // register written so far in the packet
    logic feeding;
    logic [dataWidth-1:0] archRegs [32];     // architectural state, x0 stays zero
    logic [regAddrWidth+dataWidth-1:0] expected [$];  // {dest, data}

    dualIssueCore DUT (.*);

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    task automatic compareValue(input string what, input logic [31:0] actual,
                                input logic [31:0] wanted);
        if (actual !== wanted) begin
            errorCount++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, actual, wanted);
        end
    endtask

    // --------------------------------------------------
    // random instruction words
    function automatic logic [4:0] randReg();
        logic [31:0] bits;
        bits = $random(seed);
        return {2'b00, bits[2:0]};  // x0..x7 only
    endfunction

    function automatic logic [31:0] randomWord();
        logic [31:0] bits;
        int pick;
        instrWord w;
        pick = $unsigned($random(seed)) % 10;
        bits = $random(seed);
        w = '0;                     // pick 0 leaves an all-zero word
        if (pick >= 1 && pick < 5) begin
            w.r.opcode = opcodeReg;
            w.r.funct3 = bits[2:0];
            w.r.funct7 = (bits[3] && (bits[2:0] == 3'b000 || bits[2:0] == 3'b101)) ?
                         7'b0100000 : 7'b0000000;
            w.r.rd = randReg();
            w.r.rs1 = randReg();
            w.r.rs2 = randReg();
        end else if (pick >= 5 && pick < 9) begin
            w.i.opcode = opcodeImm;
            w.i.funct3 = bits[2:0];
            w.i.rd = randReg();
            w.i.rs1 = randReg();
            if (bits[2:0] == 3'b001)
                w.i.imm12 = {7'b0, bits[8:4]};
            else if (bits[2:0] == 3'b101)
                w.i.imm12 = {1'b0, bits[3], 5'b0, bits[8:4]};  // srli or srai
            else
                w.i.imm12 = bits[31:20];
        end else if (pick == 9) begin
            w.i.opcode = opcodeLui;
            w.i.rd = randReg();
            w.i.imm12 = bits[31:20];
            w.i.rs1 = bits[19:15];
            w.i.funct3 = bits[14:12];
        end
        return w;
    endfunction

    // --------------------------------------------------
    // reference model
    function automatic logic [31:0] lessSigned(input logic [31:0] a, input logic [31:0] b);
        if (a[31] != b[31])
            return {31'b0, a[31]};  // signs differ, negative one is less
        else
            return {31'b0, a < b};
    endfunction

    function automatic logic [31:0] shiftRightArith(input logic [31:0] a,
                                                    input logic [4:0] amount);
        logic [31:0] fill;
        fill = a[31] ? ~(32'hffff_ffff >> amount) : 32'h0;
        return (a >> amount) | fill;
    endfunction

    task automatic executeModel(input logic [31:0] word, output logic conflict);
        instrWord w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] result;
        logic writes;
        w = word;
        a = archRegs[w.r.rs1];
        b = archRegs[w.r.rs2];
        imm = {{20{w.i.imm12[11]}}, w.i.imm12};
        result = '0;
        writes = 1'b1;
        case (w.r.opcode)
            opcodeReg: case ({w.r.funct7, w.r.funct3})
                {7'h00, 3'b000}: result = a + b;
                {7'h20, 3'b000}: result = a - b;
                {7'h00, 3'b001}: result = a << b[4:0];
                {7'h00, 3'b010}: result = lessSigned(a, b);
                {7'h00, 3'b011}: result = {31'b0, a < b};
                {7'h00, 3'b100}: result = a ^ b;
                {7'h00, 3'b101}: result = a >> b[4:0];
                {7'h20, 3'b101}: result = shiftRightArith(a, b[4:0]);
                {7'h00, 3'b110}: result = a | b;
                {7'h00, 3'b111}: result = a & b;
                default: writes = 1'b0;
            endcase
            opcodeImm: case (w.i.funct3)
                3'b000: result = a + imm;
                3'b010: result = lessSigned(a, imm);
                3'b011: result = {31'b0, a < imm};
                3'b100: result = a ^ imm;
                3'b110: result = a | imm;
                3'b001: begin
                    writes = w.i.imm12[11:5] == 7'h00;
                    result = a << w.i.imm12[4:0];
                end
                3'b101: begin
                    writes = w.i.imm12[11:5] == 7'h00 || w.i.imm12[11:5] == 7'h20;
                    result = w.i.imm12[10] ? shiftRightArith(a, w.i.imm12[4:0]) :
                                             a >> w.i.imm12[4:0];
                end
                default: result = a & imm;
            endcase
            opcodeLui: result = {word[31:12], 12'b0};
            default: writes = 1'b0;
        endcase
        // reads or rewrites the register an older slot wrote
        conflict = writes && packetDest != 5'd0 &&
                   (w.r.rd == packetDest ||
                    (w.r.opcode != opcodeLui && w.r.rs1 == packetDest) ||
                    (w.r.opcode == opcodeReg && w.r.rs2 == packetDest));
        if (writes && w.r.rd != 5'd0) begin
            archRegs[w.r.rd] = result;
            expected.push_back({w.r.rd, result});
            packetDest = w.r.rd;
        end
    endtask

    task automatic checkWrite(input logic [4:0] dest, input logic [31:0] data,
                              input string lane);
        logic [regAddrWidth+dataWidth-1:0] entry;
        if (expected.size() == 0) begin
            errorCount++;
            $display("lane %s wrote x%0d at %0t ns although no write was expected",
                     lane, dest, $time);
        end else begin
            entry = expected.pop_front();
            compareValue({"lane ", lane, " destination"}, {27'b0, dest}, {27'b0, entry[36:32]});
            compareValue({"lane ", lane, " data"}, data, entry[31:0]);
            checkedCount++;
        end
    endtask

    // --------------------------------------------------
    // monitor, samples mid-cycle
    always @(negedge clock) begin
        if (!reset) begin
            if (wbWriteA)
                checkWrite(wbDestA, wbDataA, "A");  // A is older
            if (wbWriteB)
                checkWrite(wbDestB, wbDataB, "B");
            compareValue("stall", {31'b0, stall}, {31'b0, splitNext});
            if (stall)
                stallCycles++;
            splitNext = 1'b0;
            if (packetValid && !stall) begin
                packetDest = '0;
                executeModel(instrA, splitNext);
                executeModel(instrB, splitNext);
                acceptedCount++;
            end
            holdPacket = packetValid && stall;
        end
    end

    always @(posedge clock) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            $display("timeout: the run did not finish within %0d cycles", cycleLimit);
            $display(">>> FAIL");
            $finish;
        end
    end

    task automatic drivePacket();
        int pick;
        pick = $unsigned($random(seed)) % 10;
        packetValid <= pick < 8;
        instrA <= randomWord();
        instrB <= randomWord();
    endtask

    initial begin
        for (int r = 0; r < 32; r++)
            archRegs[r] = '0;
        reset = 1'b1;
        packetValid = 1'b0;
        instrA = '0;
        instrB = '0;
        feeding = 1'b1;
        repeat (3) @(posedge clock);
        @(negedge clock);
        compareValue("wbWriteA in reset", {31'b0, wbWriteA}, 32'd0);
        compareValue("wbWriteB in reset", {31'b0, wbWriteB}, 32'd0);
        compareValue("stall in reset", {31'b0, stall}, 32'd0);
        @(posedge clock);
        reset <= 1'b0;
        while (feeding) begin
            @(posedge clock);
            if (acceptedCount >= packetCount) begin
                packetValid <= 1'b0;
                feeding = 1'b0;
            end else if (!holdPacket) begin
                drivePacket();  // held packet stays on the inputs
            end
        end
        while (expected.size() != 0)
            @(posedge clock);
        repeat (8) @(posedge clock);  // catch stray writes
        $display("checked %0d writes over %0d packets, %0d stall cycles, %0d errors",
                 checkedCount, acceptedCount, stallCycles, errorCount);
        if (errorCount == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

/* filelist.f */
riscPkg.sv
issueIf.sv
regFile.sv
decodeUnit.sv
executeUnit.sv
dualIssueCore.sv
dualIssueTb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = dualIssueTb
FILELIST = filelist.f
OBJDIR = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf $(OBJDIR)
